// ==== design/debounce_mono.sv ====
// debounce_mono: one-run monostable turning a bouncing button into one send pulse
`timescale 1ns/1ps
`include "ps2_defs.svh"

module debounce_mono (
	input  logic qzt_clk,
	input  logic arst_n,
	input  logic trigger,
	input  logic ms_tick,
	output logic pulse
);
	import ps2_pkg::*;

	// two sync stages then one more for the edge detect
	logic [2:0]  trig_sr;
	logic        rise;
	// monostable active
	logic        running;
	tick_count_t run_cnt;

	assign rise = trig_sr[1] & ~trig_sr[2];

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			trig_sr <= '0;
			running <= 1'b0;
			run_cnt <= '0;
			pulse   <= 1'b0;
		end else begin
			trig_sr <= {trig_sr[1:0], trigger};
			pulse   <= 1'b0;
			if (!running) begin
				// first clean edge fires and arms the run
				if (rise) begin
					pulse   <= 1'b1;
					running <= 1'b1;
					run_cnt <= '0;
				end
			end else if (ms_tick) begin
				// edges while running are dropped
				if (run_cnt == tick_count_t'(`PS2_DEBOUNCE_MS - 1))
					running <= 1'b0;
				else
					run_cnt <= run_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/ps2_defs.svh ====
// timing macros for the ps/2 host: tick periods, debounce, inhibit and timeout
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

////////////////////////////////////////
// tick periods in qzt_clk cycles
////////////////////////////////////////

// 10 MHz crystal, one microsecond
`define PS2_US_CYCLES 10
// same crystal, one millisecond
`define PS2_MS_CYCLES 10000

////////////////////////////////////////
// protocol and button timing
////////////////////////////////////////

// monostable run length in ms ticks
`define PS2_DEBOUNCE_MS 5
// host holds the device clock low this many us
`define PS2_INHIBIT_US 100
// max wait for the next device clock edge or the ack
`define PS2_TIMEOUT_MS 2

`endif

// ==== design/ps2_frame_builder.sv ====
// ps2_frame_builder: captures the byte and holds the 11-bit frame with parity
`timescale 1ns/1ps

module ps2_frame_builder (
	input  logic               qzt_clk,
	input  logic               arst_n,
	input  logic               load,
	input  ps2_pkg::ps2_byte_t  data,
	output ps2_pkg::ps2_frame_t frame
);
	import ps2_pkg::*;

	// odd parity, set when the byte has an even number of ones
	logic parity;

	assign parity = ~^data;

	// stop, parity, data lsb first, start
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			// all ones, idle line level
			frame <= '1;
		end else if (load) begin
			frame <= {1'b1, parity, data, 1'b0};
		end
	end

	// frame holds between loads
	// the controller indexes it one bit per device clock

	// Valid one cycle after load, still inside the inhibit time.

endmodule

// ==== design/ps2_host_top.sv ====
// ps2_host_top: ps/2 host transmitter top with tick dividers, debouncer and controller
`timescale 1ns/1ps
`include "ps2_defs.svh"

module ps2_host_top (
	input  logic                qzt_clk,
	input  logic                arst_n,
	input  logic                send_btn,
	input  ps2_pkg::ps2_byte_t   tx_byte,
	input  logic                ps2_clk_in,
	input  logic                ps2_data_in,
	output logic                ps2_clk_low,
	output logic                ps2_data_low,
	output ps2_pkg::ps2_status_t status
);
	import ps2_pkg::*;

	logic        us_tick;
	logic        ms_tick;
	logic        send_req;
	logic        frame_load;
	logic        cnt_start;
	logic        cnt_use_ms;
	tick_count_t cnt_limit;
	logic        carry;
	ps2_frame_t  frame;
	ps2_lines_t  lines;

	////////////////////////////////////////
	// ticks and button
	////////////////////////////////////////

	tick_divider #(.PERIOD(`PS2_US_CYCLES)) u_us_tick (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .tick(us_tick)
	);

	tick_divider #(.PERIOD(`PS2_MS_CYCLES)) u_ms_tick (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .tick(ms_tick)
	);

	debounce_mono u_debounce (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .trigger(send_btn),
		.ms_tick(ms_tick), .pulse(send_req)
	);

	////////////////////////////////////////
	// datapath around the controller
	////////////////////////////////////////

	// one counter for the inhibit and every timeout
	tick_counter u_counter (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .start(cnt_start),
		.us_tick(us_tick), .ms_tick(ms_tick), .use_ms(cnt_use_ms),
		.limit(cnt_limit), .carry(carry)
	);

	ps2_frame_builder u_frame (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .load(frame_load),
		.data(tx_byte), .frame(frame)
	);

	ps2_line_sync u_line_sync (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .ps2_clk_in(ps2_clk_in),
		.ps2_data_in(ps2_data_in), .lines(lines)
	);

	ps2_send_ctrl u_ctrl (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .send_req(send_req),
		.frame(frame), .lines(lines), .carry(carry),
		.frame_load(frame_load), .cnt_start(cnt_start),
		.cnt_use_ms(cnt_use_ms), .cnt_limit(cnt_limit),
		.ps2_clk_low(ps2_clk_low), .ps2_data_low(ps2_data_low),
		.status(status)
	);

endmodule

// ==== design/ps2_line_sync.sv ====
// ps2_line_sync: synchronizer, agreement filter and falling-edge detect for the lines
`timescale 1ns/1ps

module ps2_line_sync (
	input  logic              qzt_clk,
	input  logic              arst_n,
	input  logic              ps2_clk_in,
	input  logic              ps2_data_in,
	output ps2_pkg::ps2_lines_t lines
);
	import ps2_pkg::*;

	// bit 1 data, bit 0 clock
	logic [1:0] stage0;
	logic [1:0] stage1;
	logic [1:0] filt;
	// both sync stages agree
	logic [1:0] agree;
	// registered falling edge of the filtered clock
	logic       clk_fall_q;

	assign agree = ~(stage0 ^ stage1);

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			// lines idle high
			stage0     <= '1;
			stage1     <= '1;
			filt       <= '1;
			clk_fall_q <= 1'b0;
		end else begin
			stage0 <= {ps2_data_in, ps2_clk_in};
			stage1 <= stage0;
			// filter only follows when two samples agree
			filt   <= (filt & ~agree) | (stage1 & agree);
			// filtered clock going 1 to 0
			clk_fall_q <= filt[0] & agree[0] & ~stage1[0];
		end
	end

	assign lines.clk_fall   = clk_fall_q;
	assign lines.data_level = filt[1];

endmodule

// ==== design/ps2_pkg.sv ====
// shared types: byte, frame, tick count, status struct, line struct, controller states
package ps2_pkg;

	// command byte to the device
	typedef logic [7:0] ps2_byte_t;

	// full frame on the wire
	// bit 0 start, bits 1..8 data lsb first, bit 9 odd parity, bit 10 stop
	typedef logic [10:0] ps2_frame_t;

	// limit and count of the one-run counter
	typedef logic [7:0] tick_count_t;

	// transfer status seen by the user logic
	typedef struct packed {
		logic busy;
		logic done;
		logic acked;
		logic timed_out;
	} ps2_status_t;

	// filtered device lines
	typedef struct packed {
		logic clk_fall;
		logic data_level;
	} ps2_lines_t;

	// send controller states
	typedef enum logic [2:0] {
		IDLE, INHIBIT, REQUEST, SHIFT, ACK_WAIT, ACK_RELEASE, FINISH
	} send_state_t;

endpackage

// ==== design/ps2_send_ctrl.sv ====
// ps2_send_ctrl: FSM for inhibit, request, bit shifting, acknowledge and timeout
`timescale 1ns/1ps
`include "ps2_defs.svh"

module ps2_send_ctrl (
	input  logic                 qzt_clk,
	input  logic                 arst_n,
	input  logic                 send_req,
	input  ps2_pkg::ps2_frame_t   frame,
	input  ps2_pkg::ps2_lines_t   lines,
	input  logic                 carry,
	output logic                 frame_load,
	output logic                 cnt_start,
	output logic                 cnt_use_ms,
	output ps2_pkg::tick_count_t  cnt_limit,
	output logic                 ps2_clk_low,
	output logic                 ps2_data_low,
	output ps2_pkg::ps2_status_t  status
);
	import ps2_pkg::*;

	// index of the stop bit in the frame
	localparam logic [3:0] STOP_IDX = 4'd10;

	send_state_t state, state_nxt;
	logic [3:0]  bit_index, bit_index_nxt;
	logic        acked_q, acked_nxt;
	logic        timed_out_q, timed_out_nxt;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb begin
		state_nxt     = state;
		bit_index_nxt = bit_index;
		acked_nxt     = acked_q;
		timed_out_nxt = timed_out_q;
		frame_load    = 1'b0;
		cnt_start     = 1'b0;
		case (state)
			IDLE: begin
				// requests while busy never reach here
				if (send_req) begin
					state_nxt     = INHIBIT;
					bit_index_nxt = '0;
					acked_nxt     = 1'b0;
					timed_out_nxt = 1'b0;
					frame_load    = 1'b1;
					cnt_start     = 1'b1;
				end
			end
			INHIBIT: begin
				// end of clock low, start bit goes out
				if (carry) begin
					state_nxt = REQUEST;
					cnt_start = 1'b1;
				end
			end
			REQUEST, SHIFT: begin
				if (carry) begin
					timed_out_nxt = 1'b1;
					state_nxt     = FINISH;
				end else if (lines.clk_fall) begin
					cnt_start = 1'b1;
					// fall after the stop bit ends shifting
					if (bit_index == STOP_IDX) begin
						state_nxt = ACK_WAIT;
					end else begin
						state_nxt     = SHIFT;
						bit_index_nxt = bit_index + 1'b1;
					end
				end
			end
			ACK_WAIT: begin
				// a fall with data high is not an ack
				if (carry) begin
					timed_out_nxt = 1'b1;
					state_nxt     = FINISH;
				end else if (lines.clk_fall && !lines.data_level) begin
					acked_nxt = 1'b1;
					state_nxt = ACK_RELEASE;
					cnt_start = 1'b1;
				end
			end
			ACK_RELEASE: begin
				// wait for the device to let data go
				if (carry) begin
					timed_out_nxt = 1'b1;
					state_nxt     = FINISH;
				end else if (lines.data_level) begin
					state_nxt = FINISH;
				end
			end
			FINISH: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			bit_index   <= '0;
			acked_q     <= 1'b0;
			timed_out_q <= 1'b0;
		end else begin
			state       <= state_nxt;
			bit_index   <= bit_index_nxt;
			acked_q     <= acked_nxt;
			timed_out_q <= timed_out_nxt;
		end
	end

	////////////////////////////////////////
	// outputs decoded from state
	////////////////////////////////////////

	// us ticks for the inhibit, ms ticks for every timeout
	assign cnt_use_ms = (state != INHIBIT);
	assign cnt_limit  = cnt_use_ms ? tick_count_t'(`PS2_TIMEOUT_MS)
		: tick_count_t'(`PS2_INHIBIT_US);

	// open collector requests
	assign ps2_clk_low  = (state == INHIBIT);
	assign ps2_data_low = ((state == REQUEST) || (state == SHIFT)) && !frame[bit_index];

	assign status.busy      = (state != IDLE) && (state != FINISH);
	assign status.done      = (state == FINISH);
	assign status.acked     = acked_q;
	assign status.timed_out = timed_out_q;

endmodule

// ==== design/tick_counter.sv ====
// tick_counter: one-run counter of us or ms ticks with a carry pulse at the limit
`timescale 1ns/1ps

module tick_counter (
	input  logic                qzt_clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                us_tick,
	input  logic                ms_tick,
	input  logic                use_ms,
	input  ps2_pkg::tick_count_t limit,
	output logic                carry
);
	import ps2_pkg::*;

	tick_count_t cnt;
	logic        running;
	// selected enable
	logic        tick;

	assign tick = use_ms ? ms_tick : us_tick;

	// first tick after start only aligns to the tick grid
	// so at least limit whole periods pass before carry
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt     <= '0;
			running <= 1'b0;
			carry   <= 1'b0;
		end else begin
			carry <= 1'b0;
			if (start) begin
				// restart wins over a tick in the same cycle
				cnt     <= '0;
				running <= 1'b1;
			end else if (running && tick) begin
				if (cnt == limit) begin
					carry   <= 1'b1;
					running <= 1'b0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/tick_divider.sv ====
// tick_divider: free-running counter giving a one-cycle enable every PERIOD cycles
`timescale 1ns/1ps

module tick_divider #(
	parameter int PERIOD = 10
) (
	input  logic qzt_clk,
	input  logic arst_n,
	output logic tick
);

	// counter wide enough for PERIOD-1
	localparam int CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;

	logic [CW-1:0] cnt;

	// wraps at PERIOD-1
	// tick is registered so it lines up with the wrap
	always_ff @(posedge qzt_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			if (cnt == CW'(PERIOD - 1)) begin
				cnt  <= '0;
				// end of period
				tick <= 1'b1;
			end else begin
				cnt  <= cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

	// note: tick is an enable for qzt_clk logic
	// never used as a clock anywhere in the design

	// one instance per tick rate at the top level
	// microsecond and millisecond

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the ps/2 host testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_ps2_host -o tb_ps2_host \
	> build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_ps2_host > sim.log 2>&1
grep -q "^TEST PASSED$" sim.log && echo "simulation passed, see sim.log" || {
	echo "simulation failed, see sim.log"
	exit 1
}

// ==== tb/ps2_device_model.sv ====
// behavioral ps/2 device: open-collector line resolution, frame receive, optional ack
`timescale 1ns/1ps

module ps2_device_model #(
	// half of the 40 us device clock in qzt_clk cycles
	parameter int HALF_CYCLES = 200
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ack_en,
	input  logic       host_clk_low,
	input  logic       host_data_low,
	output logic       ps2_clk,
	output logic       ps2_data,
	output logic [7:0] rx_byte,
	output logic       rx_parity,
	output logic       rx_stop,
	output logic       parity_odd,
	output int         frame_count
);

	typedef enum logic [2:0] {
		M_IDLE, M_INHIBIT, M_REQUEST, M_LOW, M_HIGH
	} model_state_t;

	model_state_t phase;
	logic         dev_clk_low;
	logic         dev_data_low;
	// ack latched at the request
	logic         do_ack;
	// data, parity, stop, shifted in lsb first
	logic [9:0]   bits;
	int           half_cnt;
	int           pulse;

	// wired and of both sides
	assign ps2_clk  = ~(host_clk_low | dev_clk_low);
	assign ps2_data = ~(host_data_low | dev_data_low);

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase        <= M_IDLE;
			dev_clk_low  <= 1'b0;
			dev_data_low <= 1'b0;
			do_ack       <= 1'b0;
			bits         <= '0;
			half_cnt     <= 0;
			pulse        <= 0;
			rx_byte      <= '0;
			rx_parity    <= 1'b0;
			rx_stop      <= 1'b0;
			parity_odd   <= 1'b0;
			frame_count  <= 0;
		end else begin
			case (phase)
				// host inhibit starts
				M_IDLE: if (!ps2_clk) phase <= M_INHIBIT;
				M_INHIBIT: begin
					// clock released with data low is a request to send
					if (ps2_clk) begin
						phase    <= ps2_data ? M_IDLE : M_REQUEST;
						half_cnt <= 0;
						pulse    <= 0;
						do_ack   <= ack_en;
					end
				end
				M_REQUEST: begin
					if (half_cnt == HALF_CYCLES - 1) begin
						half_cnt    <= 0;
						pulse       <= 1;
						dev_clk_low <= 1'b1;
						phase       <= M_LOW;
					end else begin
						half_cnt <= half_cnt + 1;
					end
				end
				M_LOW: begin
					if (half_cnt == HALF_CYCLES - 1) begin
						// rising edge, sample the bit the host set up
						half_cnt    <= 0;
						dev_clk_low <= 1'b0;
						phase       <= M_HIGH;
						if (pulse <= 10)
							bits <= {ps2_data, bits[9:1]};
						// ack data goes low after the stop bit
						if (pulse == 10 && do_ack)
							dev_data_low <= 1'b1;
					end else begin
						half_cnt <= half_cnt + 1;
					end
				end
				M_HIGH: begin
					if (half_cnt != HALF_CYCLES - 1) begin
						half_cnt <= half_cnt + 1;
					end else if (pulse == (do_ack ? 12 : 11)) begin
						// frame complete, release data
						half_cnt     <= 0;
						dev_data_low <= 1'b0;
						rx_byte      <= bits[7:0];
						rx_parity    <= bits[8];
						rx_stop      <= bits[9];
						parity_odd   <= ^bits[8:0];
						frame_count  <= frame_count + 1;
						phase        <= M_IDLE;
					end else begin
						half_cnt    <= 0;
						pulse       <= pulse + 1;
						dev_clk_low <= 1'b1;
						phase       <= M_LOW;
					end
				end
				default: phase <= M_IDLE;
			endcase
		end
	end

endmodule

// ==== tb/ps2_testdata.txt ====
# columns: command byte (hex), device ack flag, expected acked, button bounce count
# lines starting with # are skipped
ff 1 1 0
ed 1 1 3
f4 1 1 1
00 1 1 5
a5 0 0 2
5a 1 1 4
f3 1 1 0
01 0 0 6
80 1 1 2
3c 1 1 1
c3 0 0 3
ee 1 1 5
f2 1 1 0
7e 1 1 6
aa 0 0 1
55 1 1 2

// ==== tb/tb_ps2_host.sv ====
// testbench top: clock, reset, device model, testdata reader, value check, closing report
`timescale 1ns/1ps
`include "ps2_defs.svh"

module tb_ps2_host;
	import ps2_pkg::*;

	// cycle limits for the handshake waits
	localparam int BUSY_LIMIT  = 2000;
	localparam int DONE_LIMIT  = 80000;
	// idle gap, longer than the debounce run
	localparam int GAP_CYCLES  = 60000;
	localparam int MIN_INHIBIT = `PS2_INHIBIT_US * `PS2_US_CYCLES;

	logic        qzt_clk;
	logic        arst_n;
	logic        send_btn;
	ps2_byte_t   tx_byte;
	logic        ack_en;
	logic        ps2_clk_low;
	logic        ps2_data_low;
	ps2_status_t status;
	logic        ps2_clk;
	logic        ps2_data;
	logic [7:0]  rx_byte;
	logic        rx_parity;
	logic        rx_stop;
	logic        parity_odd;
	int          frame_count;

	int error_count;
	int fail_count;
	int check_count;
	int vector_count;
	int seed;
	bit aborted;
	// written by the pin monitor only
	int done_count;
	int low_run;
	int inhibit_len;

	ps2_host_top u_dut (
		.qzt_clk(qzt_clk), .arst_n(arst_n), .send_btn(send_btn), .tx_byte(tx_byte),
		.ps2_clk_in(ps2_clk), .ps2_data_in(ps2_data),
		.ps2_clk_low(ps2_clk_low), .ps2_data_low(ps2_data_low), .status(status)
	);

	ps2_device_model u_device (
		.clk(qzt_clk), .arst_n(arst_n), .ack_en(ack_en),
		.host_clk_low(ps2_clk_low), .host_data_low(ps2_data_low),
		.ps2_clk(ps2_clk), .ps2_data(ps2_data), .rx_byte(rx_byte),
		.rx_parity(rx_parity), .rx_stop(rx_stop), .parity_odd(parity_odd),
		.frame_count(frame_count)
	);

	// 10 MHz crystal
	initial begin
		qzt_clk = 1'b0;
		forever #50 qzt_clk = ~qzt_clk;
	end

	////////////////////////////////////////
	// pin monitor
	////////////////////////////////////////

	// done pulses and length of each clock-low run
	always @(negedge qzt_clk) begin
		if (!arst_n) begin
			done_count  <= 0;
			low_run     <= 0;
			inhibit_len <= 0;
		end else begin
			if (status.done)
				done_count <= done_count + 1;
			if (ps2_clk_low) begin
				low_run <= low_run + 1;
			end else if (low_run != 0) begin
				inhibit_len <= low_run;
				low_run     <= 0;
			end
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// n rising edges, then the drive offset
	task automatic drive_point(input int n);
		repeat (n) @(posedge qzt_clk);
		#10;
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, msg, actual,
				expected);
		end
	endtask

	// bounces land well inside the debounce run, then the button is held
	task automatic press_button(input int bounces);
		int i;
		int gap;
		for (i = 0; i < bounces; i++) begin
			send_btn = ~send_btn;
			gap = 5 + ($random(seed) & 32'hff);
			drive_point(gap);
		end
		send_btn = 1'b1;
	endtask

	task automatic wait_busy(output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < BUSY_LIMIT) begin
			@(negedge qzt_clk);
			ok = status.busy;
			n++;
		end
	endtask

	task automatic wait_done(output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < DONE_LIMIT) begin
			@(negedge qzt_clk);
			ok = status.done;
			n++;
		end
	endtask

	// odd parity, data plus parity hold an odd number of ones
	function automatic logic odd_parity_bit(input logic [7:0] b);
		int ones;
		int i;
		logic [7:0] tmp;
		ones = 0;
		tmp  = b;
		for (i = 0; i < 8; i++) begin
			ones = ones + 32'(tmp[0]);
			tmp  = tmp >> 1;
		end
		return (ones % 2 == 0) ? 1'b1 : 1'b0;
	endfunction

	task automatic run_vector(input logic [7:0] b, input bit ack, input bit exp_acked,
		input int bounces);
		int frames_before;
		int dones_before;
		bit ok;
		frames_before = frame_count;
		dones_before  = done_count;
		vector_count++;
		drive_point(1);
		tx_byte = b;
		ack_en  = ack;
		press_button(bounces);
		wait_busy(ok);
		if (!ok) begin
			fail_count++;
			aborted = 1'b1;
			$display("busy never rose after the press of vector %0d", vector_count);
		end else begin
			// second press while the transfer runs
			drive_point(10);
			send_btn = 1'b0;
			drive_point(10);
			send_btn = 1'b1;
			@(negedge qzt_clk);
			check_value(32'(status.busy), 1, "busy during the second press");
			wait_done(ok);
			if (!ok) begin
				fail_count++;
				aborted = 1'b1;
				$display("done never pulsed for vector %0d, transfer stalled",
					vector_count);
			end else begin
				check_value(32'(status.busy), 0, "busy at done");
				check_value(32'(status.acked), 32'(exp_acked), "acked at done");
				check_value(32'(status.timed_out), 32'(!exp_acked), "timed_out at done");
				drive_point(1);
				send_btn = 1'b0;
				drive_point(GAP_CYCLES);
				@(negedge qzt_clk);
				check_value(frame_count - frames_before, 1, "frames per press");
				check_value(done_count - dones_before, 1, "done pulses per press");
				check_value(32'(rx_byte), 32'(b), "byte at device");
				check_value(32'(rx_parity), 32'(odd_parity_bit(b)), "parity bit");
				check_value(32'(parity_odd), 1, "odd parity over data and parity");
				check_value(32'(rx_stop), 1, "stop bit");
				check_value(32'(inhibit_len >= MIN_INHIBIT), 1, "inhibit length");
			end
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int fd;
		string line;
		int fields;
		logic [7:0] vec_byte;
		int vec_ack;
		int vec_exp;
		int vec_bounce;
		bit reading;
		seed         = 83121;
		error_count  = 0;
		fail_count   = 0;
		check_count  = 0;
		vector_count = 0;
		aborted      = 1'b0;
		arst_n       = 1'b0;
		send_btn     = 1'b0;
		tx_byte      = '0;
		ack_en       = 1'b0;
		drive_point(16);
		arst_n = 1'b1;
		// idle lines, nothing pressed yet
		drive_point(20);
		@(negedge qzt_clk);
		check_value(32'(ps2_clk_low), 0, "clock pull-low after reset");
		check_value(32'(ps2_data_low), 0, "data pull-low after reset");
		check_value(32'(status), 0, "status after reset");
		fd = $fopen("tb/ps2_testdata.txt", "r");
		if (fd == 0) begin
			fail_count++;
			$display("could not open tb/ps2_testdata.txt");
		end
		reading = (fd != 0);
		while (reading && !aborted) begin
			if ($fgets(line, fd) == 0) begin
				reading = 1'b0;
			end else if (line.len() > 0 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %d %d %d", vec_byte, vec_ack, vec_exp,
					vec_bounce);
				if (fields == 4)
					run_vector(vec_byte, vec_ack != 0, vec_exp != 0, vec_bounce);
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (vector_count == 0) begin
			fail_count++;
			$display("no test vectors were run");
		end
		$display("checks %0d, value errors %0d, other failures %0d", check_count,
			error_count, fail_count);
		if (error_count == 0 && fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+design
design/ps2_pkg.sv
design/tick_divider.sv
design/debounce_mono.sv
design/tick_counter.sv
design/ps2_frame_builder.sv
design/ps2_line_sync.sv
design/ps2_send_ctrl.sv
design/ps2_host_top.sv
tb/ps2_device_model.sv
tb/tb_ps2_host.sv
